// ==== Makefile ====
# Verilator flow for the floor request controller

VERILATOR ?= verilator
TOP       ?= floor_logic_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary -j $(JOBS)
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The output is echoed and then searched, so a missing pass line fails the target
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+include
hdl/elevator_pkg.sv
hdl/request_latch.sv
hdl/request_queue.sv
hdl/dispatch_control.sv
hdl/floor_logic_top.sv
dv/floor_logic_tb.sv

// ==== include/floor_logic_tests.svh ====
`ifndef FLOOR_LOGIC_TESTS_SVH
`define FLOOR_LOGIC_TESTS_SVH

    ////////////////////////////////////////////////////////////////////////////
    // Drive helpers
    ////////////////////////////////////////////////////////////////////////////

    // Inputs change at the falling edge where outputs have settled
    task automatic next_cycle();
        @(negedge clock);
    endtask

    function automatic floor_mask_t lamp_of(input floor_t f);
        return floor_mask_t'(1) << f;
    endfunction

    task automatic park_at(input floor_t f);
        elevator_state = car_state_t'({2'b00, f});
        current_floor  = f;
    endtask

    // Each leg takes one cycle and current_floor shows the floor just left
    task automatic travel(input floor_t from, input floor_t to);
        floor_t f;
        f = from;
        while (f != to) begin
            current_floor = f;
            if (to > f) begin
                elevator_state = car_state_t'(6'd11 + {2'b00, f});
                f = f + 4'd1;
            end else begin
                elevator_state = car_state_t'(6'd31 - {2'b00, f});
                f = f - 4'd1;
            end
            next_cycle();
        end
    endtask

    task automatic check_dispatch(input floor_t target, input logic up, input logic active);
        check_floor("target", target, elevator_floor_selector);
        check_bit("direction", up, direction_selector);
        check_bit("activate", active, activate_elevator);
    endtask

    task automatic check_lamps(input floor_mask_t call_exp, input floor_mask_t panel_exp);
        check_mask("call lamps", call_exp, call_button_lights);
        check_mask("panel lamps", panel_exp, panel_button_lights);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_defaults();
        test_name = "reset_defaults";
        next_cycle();
        check_lamps('0, '0);
        check_dispatch(FLOOR_BOTTOM, 1'b1, 1'b0);
    endtask

    task automatic single_trip();
        test_name = "single_trip";
        park_at(4'd0);
        panel_buttons = lamp_of(4'd4);
        next_cycle();
        check_lamps('0, lamp_of(4'd4));
        panel_buttons = '0;
        next_cycle();
        check_dispatch(4'd4, 1'b1, 1'b1);
        travel(4'd0, 4'd4);
        check_floor("target while moving", 4'd4, elevator_floor_selector);
        park_at(4'd4);
        next_cycle();
        check_lamps('0, '0);
        check_bit("activate after serve", 1'b0, activate_elevator);
        // Call from below the car
        floor_call_buttons = lamp_of(4'd1);
        next_cycle();
        floor_call_buttons = '0;
        next_cycle();
        check_lamps(lamp_of(4'd1), '0);
        check_dispatch(4'd1, 1'b0, 1'b1);
        travel(4'd4, 4'd1);
        park_at(4'd1);
        next_cycle();
        check_lamps('0, '0);
        check_bit("activate after serve", 1'b0, activate_elevator);
    endtask

    task automatic queue_order();
        floor_t      order [5];
        floor_mask_t call_exp;
        floor_mask_t panel_exp;
        floor_t      here;
        test_name = "queue_order";
        order     = '{4'd7, 4'd2, 4'd9, 4'd5, 4'd6};
        here      = 4'd1;
        current_floor  = here;
        elevator_state = UP_F2_F3;
        floor_call_buttons = lamp_of(4'd7);
        next_cycle();
        floor_call_buttons = '0;
        panel_buttons      = lamp_of(4'd2);
        next_cycle();
        panel_buttons      = '0;
        floor_call_buttons = lamp_of(4'd9);
        next_cycle();
        // Panel and call in the same cycle go in panel first
        floor_call_buttons = lamp_of(4'd6);
        panel_buttons      = lamp_of(4'd5);
        next_cycle();
        floor_call_buttons = '0;
        panel_buttons      = '0;
        call_exp  = lamp_of(4'd7) | lamp_of(4'd9) | lamp_of(4'd6);
        panel_exp = lamp_of(4'd2) | lamp_of(4'd5);
        check_lamps(call_exp, panel_exp);
        park_at(here);
        foreach (order[i]) begin
            next_cycle();
            check_dispatch(order[i], order[i] > here, 1'b1);
            park_at(order[i]);
            next_cycle();
            call_exp  = call_exp & ~lamp_of(order[i]);
            panel_exp = panel_exp & ~lamp_of(order[i]);
            check_lamps(call_exp, panel_exp);
            check_bit("activate after serve", 1'b0, activate_elevator);
            here = order[i];
        end
    endtask

    task automatic ignored_requests();
        test_name = "ignored_requests";
        park_at(4'd6);
        panel_buttons = lamp_of(4'd6);
        next_cycle();
        panel_buttons = '0;
        check_lamps('0, '0);
        // An entry for the floor just left would start a trip from here
        park_at(4'd4);
        next_cycle();
        check_bit("activate for current floor", 1'b0, activate_elevator);
        floor_call_buttons = lamp_of(4'd2);
        next_cycle();
        floor_call_buttons = '0;
        next_cycle();
        check_dispatch(4'd2, 1'b0, 1'b1);
        // Pressing a lit button again
        floor_call_buttons = lamp_of(4'd2);
        next_cycle();
        floor_call_buttons = '0;
        check_lamps(lamp_of(4'd2), '0);
        park_at(4'd2);
        next_cycle();
        check_lamps('0, '0);
        // A duplicate entry would start a new trip from here
        park_at(4'd4);
        next_cycle();
        check_bit("activate after move", 1'b0, activate_elevator);
        next_cycle();
        check_dispatch(4'd2, 1'b0, 1'b0);
    endtask

    task automatic emergency_and_power_off();
        test_name = "emergency";
        panel_buttons      = lamp_of(4'd8);
        floor_call_buttons = lamp_of(4'd0);
        next_cycle();
        panel_buttons      = '0;
        floor_call_buttons = '0;
        check_lamps(lamp_of(4'd0), lamp_of(4'd8));
        emergency_btn = 1'b1;
        next_cycle();
        check_lamps('0, '0);
        check_dispatch(FLOOR_EMERGENCY, 1'b1, 1'b0);
        emergency_btn = 1'b0;
        next_cycle();
        check_dispatch(FLOOR_EMERGENCY, 1'b1, 1'b0);

        test_name = "power_off";
        floor_call_buttons = lamp_of(4'd3);
        next_cycle();
        floor_call_buttons = '0;
        next_cycle();
        check_lamps(lamp_of(4'd3), '0);
        check_dispatch(4'd3, 1'b0, 1'b1);
        power_switch = 1'b0;
        next_cycle();
        check_lamps('0, '0);
        check_dispatch(4'd3, 1'b0, 1'b0);
        panel_buttons = lamp_of(4'd1);
        next_cycle();
        check_lamps('0, '0);
        panel_buttons = '0;
        power_switch  = 1'b1;
        next_cycle();
        next_cycle();
        check_lamps('0, '0);
        check_dispatch(4'd3, 1'b0, 1'b0);
    endtask

    task automatic door_permissions();
        logic [31:0] r;
        logic        enabled;
        test_name = "door_permissions";
        repeat (200) begin
            next_cycle();
            r = $random(seed);
            elevator_state = car_state_t'({1'b0, r[4:0]});
            // Power is on three cycles in four
            power_switch   = r[8] | r[9];
            door_open_btn  = r[12];
            door_close_btn = r[13];
            #2;
            enabled = ({1'b0, r[4:0]} <= 6'd10) && power_switch;
            check_bit("door open", enabled & door_open_btn, door_open_allowed);
            check_bit("door close", enabled & door_close_btn, door_close_allowed);
        end
        next_cycle();
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        power_switch   = 1'b1;
        park_at(4'd0);
    endtask

`endif

// ==== dv/floor_logic_tb.sv ====
`timescale 1ns/1ps

module floor_logic_tb;

    import elevator_pkg::*;

    // All tests together take about 300 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    car_state_t  elevator_state;
    floor_t      elevator_floor_selector;
    logic        direction_selector;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;

    integer seed;
    int     cycle_count;
    string  test_name;

    floor_logic_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH_DEFAULT)
    ) UUT (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor           (current_floor),
        .elevator_state          (elevator_state),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_floor(input string what, input floor_t expected, input floor_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
            abort_run("floor value mismatch");
        end
    endtask

    task automatic check_mask(input string what, input floor_mask_t expected,
                              input floor_mask_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: %s expected 'b%011b, actual 'b%011b",
                     test_name, what, expected, actual);
            abort_run("lamp mask mismatch");
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: %s expected %b, actual %b",
                     test_name, what, expected, actual);
            abort_run("single bit mismatch");
        end
    endtask

    `include "floor_logic_tests.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and timeout
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed               = 32'ha9f9_0fc5;
        test_name          = "setup";
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = 4'd0;
        elevator_state     = STOP_FL1;
        repeat (8) @(negedge clock);
        reset_n = 1'b1;
        reset_defaults();
        single_trip();
        queue_order();
        ignored_requests();
        emergency_and_power_off();
        door_permissions();
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        abort_run("timeout");
    end

endmodule

// ==== hdl/dispatch_control.sv ====
`timescale 1ns/1ps

module dispatch_control (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     power_switch,
    input  logic                     emergency_btn,
    input  logic                     door_open_btn,
    input  logic                     door_close_btn,
    input  elevator_pkg::car_state_t elevator_state,
    input  elevator_pkg::floor_t     current_floor,
    input  elevator_pkg::floor_t     head_floor,
    input  logic                     empty,
    output logic                     pop,
    output logic                     serve,
    output logic                     flush,
    output elevator_pkg::floor_t     elevator_floor_selector,
    output logic                     direction_selector,
    output logic                     activate_elevator,
    output logic                     door_open_allowed,
    output logic                     door_close_allowed
);

    import elevator_pkg::*;

    logic car_stopped;
    logic serve_now;
    logic head_pending;
    logic head_above;

    ////////////////////////////////////////////////////////////////////////////
    // State decode
    ////////////////////////////////////////////////////////////////////////////

    // Stop states occupy the lowest codes
    assign car_stopped = (elevator_state <= STOP_FL11);

    // Requests are dropped while power is off or emergency is held
    assign flush = !power_switch || emergency_btn;

    // Head request exists and is somewhere other than here
    assign head_pending = !empty && (head_floor != current_floor);
    assign head_above   = (head_floor > current_floor);

    ////////////////////////////////////////////////////////////////////////////
    // Serve
    ////////////////////////////////////////////////////////////////////////////

    // Car is parked at the oldest request
    assign serve_now = car_stopped && power_switch && !emergency_btn &&
                       !empty && (head_floor == current_floor);

    // Queue pop and lamp clear act together
    assign pop   = serve_now;
    assign serve = serve_now;

    ////////////////////////////////////////////////////////////////////////////
    // Target, direction and activation
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            elevator_floor_selector <= FLOOR_BOTTOM;
            direction_selector      <= 1'b1;
            activate_elevator       <= 1'b0;
        end else if (!power_switch) begin
            // Target and direction hold through power-off
            activate_elevator <= 1'b0;
        end else if (emergency_btn) begin
            elevator_floor_selector <= FLOOR_EMERGENCY;
            direction_selector      <= 1'b1;
            activate_elevator       <= 1'b0;
        end else begin
            // Only a stopped car takes a new target
            if (car_stopped && !empty) begin
                elevator_floor_selector <= head_floor;
                direction_selector      <= head_above;
            end
            activate_elevator <= car_stopped && head_pending;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Door permissions
    ////////////////////////////////////////////////////////////////////////////

    // Doors follow their buttons only when parked with power on
    always_comb begin
        door_open_allowed  = 1'b0;
        door_close_allowed = 1'b0;
        if (car_stopped && power_switch) begin
            door_open_allowed  = door_open_btn;
            door_close_allowed = door_close_btn;
        end
    end

endmodule

// ==== hdl/elevator_pkg.sv ====
package elevator_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths that carry a meaning
    ////////////////////////////////////////////////////////////////////////////

    // Floor number, floor 1 is 0 and floor 11 is 10
    typedef logic [3:0]  floor_t;

    // One bit per floor, bit i is floor i+1
    typedef logic [10:0] floor_mask_t;

    // Motion FSM state code as seen on the elevator_state input
    typedef enum logic [5:0] {
        // Stopped at a floor, codes 0 to 10
        STOP_FL1 = 6'd0,
        STOP_FL2, STOP_FL3, STOP_FL4, STOP_FL5, STOP_FL6,
        STOP_FL7, STOP_FL8, STOP_FL9, STOP_FL10, STOP_FL11,
        // Travelling up, codes 11 to 20
        UP_F1_F2 = 6'd11,
        UP_F2_F3, UP_F3_F4, UP_F4_F5, UP_F5_F6,
        UP_F6_F7, UP_F7_F8, UP_F8_F9, UP_F9_F10, UP_F10_F11,
        // Travelling down, codes 21 to 30
        DOWN_F11_F10 = 6'd21,
        DOWN_F10_F9, DOWN_F9_F8, DOWN_F8_F7, DOWN_F7_F6,
        DOWN_F6_F5, DOWN_F5_F4, DOWN_F4_F3, DOWN_F3_F2, DOWN_F2_F1,
        EMERGENCY = 6'd31
    } car_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_FLOORS = 11;

    // Target floor after reset
    localparam floor_t FLOOR_BOTTOM = 4'd0;

    // Target code offered to the FSM during an emergency
    localparam floor_t FLOOR_EMERGENCY = 4'd15;

    // One slot per floor is enough for a full set of lamps in one bank
    localparam int QUEUE_DEPTH_DEFAULT = 11;

endpackage

// ==== hdl/floor_logic_top.sv ====
`timescale 1ns/1ps

module floor_logic_top #(
    parameter int QUEUE_DEPTH = elevator_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      door_open_btn,
    input  logic                      door_close_btn,
    input  logic                      emergency_btn,
    input  logic                      power_switch,
    input  elevator_pkg::floor_t      current_floor,
    input  elevator_pkg::car_state_t  elevator_state,
    output elevator_pkg::floor_t      elevator_floor_selector,
    output logic                      direction_selector,
    output logic                      activate_elevator,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed,
    output elevator_pkg::floor_mask_t call_button_lights,
    output elevator_pkg::floor_mask_t panel_button_lights
);

    import elevator_pkg::*;

    // Latch to queue
    logic   panel_push;
    floor_t panel_push_floor;
    logic   call_push;
    floor_t call_push_floor;

    // Queue to dispatcher
    floor_t head_floor;
    logic   queue_empty;

    // Dispatcher strobes
    logic   pop;
    logic   serve;
    logic   flush;

    ////////////////////////////////////////////////////////////////////////////
    // Button banks, panel takes queue port a so it is written first
    ////////////////////////////////////////////////////////////////////////////

    request_latch panel_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (panel_buttons),
        .current_floor (current_floor),
        .serve         (serve),
        .flush         (flush),
        .lights        (panel_button_lights),
        .push          (panel_push),
        .push_floor    (panel_push_floor)
    );

    request_latch call_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (floor_call_buttons),
        .current_floor (current_floor),
        .serve         (serve),
        .flush         (flush),
        .lights        (call_button_lights),
        .push          (call_push),
        .push_floor    (call_push_floor)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Request queue and dispatch
    ////////////////////////////////////////////////////////////////////////////

    request_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_request_queue (
        .clock      (clock),
        .reset_n    (reset_n),
        .push_a     (panel_push),
        .push_b     (call_push),
        .floor_a    (panel_push_floor),
        .floor_b    (call_push_floor),
        .pop        (pop),
        .flush      (flush),
        .head_floor (head_floor),
        .empty      (queue_empty)
    );

    dispatch_control u_dispatch_control (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .elevator_state          (elevator_state),
        .current_floor           (current_floor),
        .head_floor              (head_floor),
        .empty                   (queue_empty),
        .pop                     (pop),
        .serve                   (serve),
        .flush                   (flush),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

// ==== hdl/request_latch.sv ====
`timescale 1ns/1ps

module request_latch (
    input  logic                     clock,
    input  logic                     reset_n,
    input  elevator_pkg::floor_mask_t buttons,
    input  elevator_pkg::floor_t      current_floor,
    input  logic                     serve,
    input  logic                     flush,
    output elevator_pkg::floor_mask_t lights,
    output logic                     push,
    output elevator_pkg::floor_t      push_floor
);

    import elevator_pkg::*;

    floor_mask_t current_mask;
    floor_mask_t eligible;
    floor_mask_t set_mask;
    floor_mask_t clear_mask;
    logic        pick_valid;
    floor_t      pick_floor;

    ////////////////////////////////////////////////////////////////////////////
    // Request selection
    ////////////////////////////////////////////////////////////////////////////

    // An out of range floor code gives an empty mask
    assign current_mask = floor_mask_t'(1) << current_floor;

    // Pressed, not yet lit, and not the floor the car is at
    assign eligible = buttons & ~lights & ~current_mask;

    // Lowest eligible floor wins, the rest wait for a later cycle
    always_comb begin
        pick_valid = 1'b0;
        pick_floor = FLOOR_BOTTOM;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (eligible[i] && !pick_valid) begin
                pick_valid = 1'b1;
                pick_floor = floor_t'(i);
            end
        end
    end

    // New request goes to the queue at the same edge that lights the lamp
    assign push       = pick_valid && !flush;
    assign push_floor = pick_floor;

    ////////////////////////////////////////////////////////////////////////////
    // Lamp register
    ////////////////////////////////////////////////////////////////////////////

    assign set_mask   = pick_valid ? (floor_mask_t'(1) << pick_floor) : '0;
    assign clear_mask = serve ? current_mask : '0;

    // Set and clear never touch the same bit since the current floor is excluded
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else if (flush) begin
            lights <= '0;
        end else begin
            lights <= (lights & ~clear_mask) | set_mask;
        end
    end

endmodule

// ==== hdl/request_queue.sv ====
`timescale 1ns/1ps

module request_queue #(
    parameter int QUEUE_DEPTH = elevator_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 push_a,
    input  logic                 push_b,
    input  elevator_pkg::floor_t floor_a,
    input  elevator_pkg::floor_t floor_b,
    input  logic                 pop,
    input  logic                 flush,
    output elevator_pkg::floor_t head_floor,
    output logic                 empty
);

    import elevator_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_PTR   = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(QUEUE_DEPTH);

    floor_t           mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_b_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_a;
    logic [CNT_W-1:0] count_next;
    logic             accept_a;
    logic             accept_b;
    logic             do_pop;

    // Pointer step with wrap, the depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == LAST_PTR) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Write and read qualification
    ////////////////////////////////////////////////////////////////////////////

    // Port a is written first, port b only if room is left after it
    assign accept_a = push_a && !flush && (count != FULL_COUNT);
    assign count_a  = count + CNT_W'(accept_a);
    assign accept_b = push_b && !flush && (count_a != FULL_COUNT);
    assign wr_b_ptr = accept_a ? ptr_inc(wr_ptr) : wr_ptr;

    assign do_pop = pop && !flush && (count != '0);

    assign count_next = count_a + CNT_W'(accept_b) - CNT_W'(do_pop);

    // Storage
    always_ff @(posedge clock) begin
        if (accept_a) begin
            mem[wr_ptr] <= floor_a;
        end
        if (accept_b) begin
            mem[wr_b_ptr] <= floor_b;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
        end else begin
            if (accept_b) begin
                wr_ptr <= ptr_inc(wr_b_ptr);
            end else if (accept_a) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count_next;
            empty <= (count_next == '0);
        end
    end

    // Oldest request, valid whenever empty is low
    assign head_floor = mem[rd_ptr];

endmodule
